// File: iq_pkg.sv
package iq_pkg;

    // physical register file, register 0 is hardwired and never pending
    localparam int PREG_W    = 6;
    localparam int NUM_PREGS = 1 << PREG_W;

    // issue queue geometry
    localparam int IQ_DEPTH  = 8;
    localparam int IQ_IDX_W  = 3;

    localparam int ROB_ID_W  = 6;
    localparam int PC_W      = 32;

    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_and    = 4'd2,
        op_or     = 4'd3,
        op_xor    = 4'd4,
        op_sll    = 4'd5,
        op_srl    = 4'd6,
        op_sra    = 4'd7,
        op_slt    = 4'd8,
        op_sltu   = 4'd9,
        op_lui    = 4'd10,
        op_branch = 4'd11,
        op_load   = 4'd12,
        op_store  = 4'd13
    } alu_op_e;

    // micro-op as handed over by rename
    typedef struct packed {
        logic [PC_W-1:0]     pc;
        logic [31:0]         instr;
        logic [31:0]         imm;
        logic [PREG_W-1:0]   prs1;
        logic [PREG_W-1:0]   prs2;
        logic [PREG_W-1:0]   prd;
        logic                src1_is_reg;  // 0 means imm or pc operand
        logic                src2_is_reg;
        logic                need_to_wb;
        alu_op_e             alu_op;
        logic                is_load;
        logic                is_store;
        logic [1:0]          ls_size;      // byte, half, word
        logic [ROB_ID_W-1:0] rob_id;
    } iq_uop_t;

    // writeback broadcast from the execution side
    typedef struct packed {
        logic              valid;
        logic [PREG_W-1:0] prd;
    } wb_t;

endpackage

// File: iq_entry.sv
`timescale 1ns/100ps

module iq_entry (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             enq_valid,
    input  iq_pkg::iq_uop_t  enq_uop,
    input  logic             enq_src1_pending,
    input  logic             enq_src2_pending,
    input  logic             wakeup_src1,
    input  logic             wakeup_src2,
    input  logic             issuing,
    input  logic             flush,
    output logic             valid,
    output logic             ready_to_go,
    output iq_pkg::iq_uop_t  uop
);

    logic            valid_q;
    logic            src1_pending_q;
    logic            src2_pending_q;
    iq_pkg::iq_uop_t uop_q;

    // slot occupancy, flush wins over a same-cycle enqueue
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (enq_valid) begin
            valid_q <= 1'b1;
        end else if (issuing) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            src1_pending_q <= 1'b0;
        end else if (enq_valid) begin
            src1_pending_q <= enq_src1_pending;
        end else if (wakeup_src1) begin
            src1_pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            src2_pending_q <= 1'b0;
        end else if (enq_valid) begin
            src2_pending_q <= enq_src2_pending;
        end else if (wakeup_src2) begin
            src2_pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (enq_valid) begin
            uop_q <= enq_uop;  // payload only
        end
    end

    assign valid       = valid_q;
    assign uop         = uop_q;
    assign ready_to_go = valid_q & ~src1_pending_q & ~src2_pending_q;

endmodule

// File: busy_table.sv
`timescale 1ns/100ps

module busy_table (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            enq_valid,
    input  iq_pkg::iq_uop_t enq_uop,
    input  iq_pkg::wb_t     wb,
    output logic            src1_pending,
    output logic            src2_pending
);

    logic [iq_pkg::NUM_PREGS-1:0] busy;

    logic wb_hit_src1;
    logic wb_hit_src2;
    logic set_dest;

    // same-cycle writeback bypass on the source lookup
    assign wb_hit_src1 = wb.valid && (wb.prd == enq_uop.prs1);
    assign wb_hit_src2 = wb.valid && (wb.prd == enq_uop.prs2);

    assign src1_pending = enq_uop.src1_is_reg && (enq_uop.prs1 != '0)
                          && busy[enq_uop.prs1] && !wb_hit_src1;
    assign src2_pending = enq_uop.src2_is_reg && (enq_uop.prs2 != '0)
                          && busy[enq_uop.prs2] && !wb_hit_src2;

    assign set_dest = enq_valid && enq_uop.need_to_wb && (enq_uop.prd != '0);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
        end else begin
            if (wb.valid) begin
                busy[wb.prd] <= 1'b0;
            end
            // later assignment, so a new destination beats a writeback to it
            if (set_dest) begin
                busy[enq_uop.prd] <= 1'b1;
            end
        end
    end

endmodule

// File: issue_select.sv
`timescale 1ns/100ps

module issue_select (
    input  logic [iq_pkg::IQ_DEPTH-1:0] valid_vec,
    input  logic [iq_pkg::IQ_DEPTH-1:0] ready_vec,
    output logic [iq_pkg::IQ_IDX_W-1:0] free_idx,
    output logic [iq_pkg::IQ_IDX_W-1:0] ready_idx,
    output logic                        any_ready,
    output logic                        full
);

    // lowest free slot takes the next enqueue
    always_comb begin
        free_idx = '0;
        for (int i = iq_pkg::IQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid_vec[i]) begin
                free_idx = i[iq_pkg::IQ_IDX_W-1:0];
            end
        end
    end

    // fixed priority, lowest ready slot issues
    always_comb begin
        ready_idx = '0;
        for (int i = iq_pkg::IQ_DEPTH - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                ready_idx = i[iq_pkg::IQ_IDX_W-1:0];
            end
        end
    end

    assign any_ready = |ready_vec;
    assign full      = &valid_vec;

endmodule

// File: issue_queue.sv
`timescale 1ns/100ps

module issue_queue (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            enq_valid,
    input  iq_pkg::iq_uop_t enq_uop,
    input  logic            enq_src1_pending,
    input  logic            enq_src2_pending,
    input  iq_pkg::wb_t     wb,
    input  logic            issue_stall,
    input  logic            flush,
    output logic            full,
    output logic            issue_valid,
    output iq_pkg::iq_uop_t issue_uop
);

    logic [iq_pkg::IQ_DEPTH-1:0] valid_vec;
    logic [iq_pkg::IQ_DEPTH-1:0] ready_vec;
    logic [iq_pkg::IQ_DEPTH-1:0] enq_sel;
    logic [iq_pkg::IQ_DEPTH-1:0] issue_sel;
    logic [iq_pkg::IQ_DEPTH-1:0] wakeup1;
    logic [iq_pkg::IQ_DEPTH-1:0] wakeup2;

    iq_pkg::iq_uop_t entry_uop [iq_pkg::IQ_DEPTH];

    logic [iq_pkg::IQ_IDX_W-1:0] free_idx;
    logic [iq_pkg::IQ_IDX_W-1:0] ready_idx;
    logic                        any_ready;
    logic                        enq_accept;
    logic                        issue_fire;

    assign enq_accept = enq_valid & ~full;  // enqueue into a full queue is dropped
    assign issue_fire = issue_valid & ~issue_stall;

    // one-hot decode of the chosen slots
    always_comb begin
        enq_sel = '0;
        enq_sel[free_idx] = enq_accept;
    end

    always_comb begin
        issue_sel = '0;
        issue_sel[ready_idx] = issue_fire;
    end

    for (genvar i = 0; i < iq_pkg::IQ_DEPTH; i++) begin : g_entry
        // tag match of the writeback against the stored sources
        assign wakeup1[i] = wb.valid && (wb.prd == entry_uop[i].prs1);
        assign wakeup2[i] = wb.valid && (wb.prd == entry_uop[i].prs2);

        iq_entry u_entry (
            .clock            (clock),
            .reset_n          (reset_n),
            .enq_valid        (enq_sel[i]),
            .enq_uop          (enq_uop),
            .enq_src1_pending (enq_src1_pending),
            .enq_src2_pending (enq_src2_pending),
            .wakeup_src1      (wakeup1[i]),
            .wakeup_src2      (wakeup2[i]),
            .issuing          (issue_sel[i]),
            .flush            (flush),
            .valid            (valid_vec[i]),
            .ready_to_go      (ready_vec[i]),
            .uop              (entry_uop[i])
        );
    end

    issue_select u_select (
        .valid_vec (valid_vec),
        .ready_vec (ready_vec),
        .free_idx  (free_idx),
        .ready_idx (ready_idx),
        .any_ready (any_ready),
        .full      (full)
    );

    assign issue_valid = any_ready;
    assign issue_uop   = entry_uop[ready_idx];  // held stable while stalled

endmodule

// File: iq_top.sv
`timescale 1ns/100ps

module iq_top (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            enq_valid,
    input  iq_pkg::iq_uop_t enq_uop,
    input  iq_pkg::wb_t     wb,
    input  logic            issue_stall,
    input  logic            flush,
    output logic            full,
    output logic            issue_valid,
    output iq_pkg::iq_uop_t issue_uop
);

    logic src1_pending;
    logic src2_pending;
    logic busy_enq_valid;

    // only accepted enqueues may mark a destination busy
    assign busy_enq_valid = enq_valid & ~full;

    busy_table u_busy_table (
        .clock        (clock),
        .reset_n      (reset_n),
        .enq_valid    (busy_enq_valid),
        .enq_uop      (enq_uop),
        .wb           (wb),
        .src1_pending (src1_pending),
        .src2_pending (src2_pending)
    );

    issue_queue u_issue_queue (
        .clock            (clock),
        .reset_n          (reset_n),
        .enq_valid        (enq_valid),
        .enq_uop          (enq_uop),
        .enq_src1_pending (src1_pending),
        .enq_src2_pending (src2_pending),
        .wb               (wb),
        .issue_stall      (issue_stall),
        .flush            (flush),
        .full             (full),
        .issue_valid      (issue_valid),
        .issue_uop        (issue_uop)
    );

endmodule

// File: iq_top_sva.sv
`timescale 1ns/100ps

module iq_top_sva (
    input logic            clock,
    input logic            reset_n,
    input logic            enq_valid,
    input iq_pkg::wb_t     wb,
    input logic            issue_stall,
    input logic            flush,
    input logic            full,
    input logic            issue_valid,
    input iq_pkg::iq_uop_t issue_uop
);

    // rename has to hold off while the queue is full
    property no_enq_when_full;
        @(posedge clock) disable iff (!reset_n)
        full |-> !enq_valid;
    endproperty

    // a quiet stalled cycle keeps the same micro-op on the issue port,
    // a same-cycle enqueue or wakeup may move selection to a lower slot
    property hold_under_stall;
        @(posedge clock) disable iff (!reset_n)
        (issue_valid && issue_stall && !flush && !enq_valid && !wb.valid)
            |=> (issue_valid && $stable(issue_uop));
    endproperty

    property idle_after_reset;
        @(posedge clock)
        $rose(reset_n) |-> (!issue_valid && !full);
    endproperty

    a_no_enq_when_full: assert property (no_enq_when_full)
        else $error("enqueue strobe while the issue queue is full");
    a_hold_under_stall: assert property (hold_under_stall)
        else $error("issue_uop changed while stalled");
    a_idle_after_reset: assert property (idle_after_reset)
        else $error("issue_valid or full high right after reset");

endmodule

bind iq_top iq_top_sva u_iq_top_sva (
    .clock       (clock),
    .reset_n     (reset_n),
    .enq_valid   (enq_valid),
    .wb          (wb),
    .issue_stall (issue_stall),
    .flush       (flush),
    .full        (full),
    .issue_valid (issue_valid),
    .issue_uop   (issue_uop)
);

// File: tb_iq_top.sv
`timescale 1ns/100ps

module tb_iq_top;

    localparam real CLK_PERIOD      = 4.0;
    localparam int  RESET_CYCLES    = 3;
    localparam int  DIRECTED_CYCLES = 150;  // upper bound for the directed part
    localparam int  RANDOM_CYCLES   = 2000;
    localparam int  MARGIN_CYCLES   = 200;
    localparam int  CHK_W           = 160;
    localparam int  DEPTH           = iq_pkg::IQ_DEPTH;
    localparam int  IDX_W           = iq_pkg::IQ_IDX_W;

    logic            clock;
    logic            reset_n;
    logic            enq_valid;
    iq_pkg::iq_uop_t enq_uop;
    iq_pkg::wb_t     wb;
    logic            issue_stall;
    logic            flush;
    logic            full;
    logic            issue_valid;
    iq_pkg::iq_uop_t issue_uop;

    // reference queue and busy table
    logic                         ref_valid [DEPTH];
    logic                         ref_p1    [DEPTH];
    logic                         ref_p2    [DEPTH];
    iq_pkg::iq_uop_t              ref_uop   [DEPTH];
    logic [iq_pkg::NUM_PREGS-1:0] ref_busy;

    bit pass_printed;
    bit fail_printed;

    iq_top dut (
        .clock       (clock),
        .reset_n     (reset_n),
        .enq_valid   (enq_valid),
        .enq_uop     (enq_uop),
        .wb          (wb),
        .issue_stall (issue_stall),
        .flush       (flush),
        .full        (full),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic ref_full();
        logic f;
        f = 1'b1;
        for (int i = 0; i < DEPTH; i++) begin
            f = f & ref_valid[i];
        end
        return f;
    endfunction

    function automatic logic ref_any_ready();
        logic r;
        r = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            r = r | (ref_valid[i] & ~ref_p1[i] & ~ref_p2[i]);
        end
        return r;
    endfunction

    function automatic logic [IDX_W-1:0] ref_ready_slot();
        logic [IDX_W-1:0] slot;
        slot = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (ref_valid[i] && !ref_p1[i] && !ref_p2[i]) begin
                slot = IDX_W'(i);
            end
        end
        return slot;
    endfunction

    function automatic logic [IDX_W-1:0] ref_free_slot();
        logic [IDX_W-1:0] slot;
        slot = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!ref_valid[i]) begin
                slot = IDX_W'(i);
            end
        end
        return slot;
    endfunction

    // one clock edge of the model with the inputs that edge samples
    function automatic void ref_advance(logic ev, iq_pkg::iq_uop_t u, iq_pkg::wb_t w,
                                        logic stall, logic fl);
        logic             accept;
        logic             fire;
        logic             pend1;
        logic             pend2;
        logic [IDX_W-1:0] rdy;
        logic [IDX_W-1:0] free;
        accept = ev && !ref_full();
        fire   = ref_any_ready() && !stall;
        rdy    = ref_ready_slot();
        free   = ref_free_slot();
        pend1  = u.src1_is_reg && (u.prs1 != '0) && ref_busy[u.prs1]
                 && !(w.valid && (w.prd == u.prs1));
        pend2  = u.src2_is_reg && (u.prs2 != '0) && ref_busy[u.prs2]
                 && !(w.valid && (w.prd == u.prs2));
        for (int i = 0; i < DEPTH; i++) begin
            if (w.valid && (w.prd == ref_uop[i].prs1)) ref_p1[i] = 1'b0;
            if (w.valid && (w.prd == ref_uop[i].prs2)) ref_p2[i] = 1'b0;
        end
        if (fire) ref_valid[rdy] = 1'b0;
        if (accept) begin
            ref_valid[free] = 1'b1;
            ref_uop[free]   = u;
            ref_p1[free]    = pend1;
            ref_p2[free]    = pend2;
        end
        if (fl) begin
            for (int i = 0; i < DEPTH; i++) ref_valid[i] = 1'b0;  // busy bits stay
        end
        if (w.valid) ref_busy[w.prd] = 1'b0;
        if (accept && u.need_to_wb && (u.prd != '0)) ref_busy[u.prd] = 1'b1;
    endfunction

    task automatic check_equal(input logic [CHK_W-1:0] actual,
                               input logic [CHK_W-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h",
                     $time, what, actual, expected);
            fail_printed = 1'b1;
            $display("Simulation failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic iq_pkg::iq_uop_t make_uop(logic [iq_pkg::PREG_W-1:0] prs1,
                                                 logic [iq_pkg::PREG_W-1:0] prs2,
                                                 logic [iq_pkg::PREG_W-1:0] prd,
                                                 logic r1, logic r2);
        iq_pkg::iq_uop_t u;
        logic [31:0]     r;
        r             = $urandom;
        u             = '0;
        u.pc          = $urandom;
        u.instr       = $urandom;
        u.imm         = $urandom;
        u.prs1        = prs1;
        u.prs2        = prs2;
        u.prd         = prd;
        u.src1_is_reg = r1;
        u.src2_is_reg = r2;
        u.need_to_wb  = (prd != '0);
        u.alu_op      = iq_pkg::alu_op_e'(4'(r % 14));
        u.is_load     = (u.alu_op == iq_pkg::op_load);
        u.is_store    = (u.alu_op == iq_pkg::op_store);
        u.ls_size     = r[5:4];
        u.rob_id      = r[21:16];
        return u;
    endfunction

    task automatic drive_idle();
        enq_valid   = 1'b0;
        enq_uop     = '0;
        wb          = '0;
        issue_stall = 1'b0;
        flush       = 1'b0;
    endtask

    task automatic enqueue(input iq_pkg::iq_uop_t u);
        enq_valid = 1'b1;
        enq_uop   = u;
    endtask

    task automatic tick();
        @(posedge clock);
        #0.5;
        drive_idle();
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    initial begin : compare
        wait (reset_n === 1'b1);
        forever begin
            @(negedge clock);  // outputs depend on entry state only
            check_equal(CHK_W'(issue_valid), CHK_W'(ref_any_ready()), "issue_valid");
            check_equal(CHK_W'(full), CHK_W'(ref_full()), "full");
            if (ref_any_ready()) begin
                check_equal(CHK_W'(issue_uop), CHK_W'(ref_uop[ref_ready_slot()]), "issue_uop");
            end
            ref_advance(enq_valid, enq_uop, wb, issue_stall, flush);
        end
    end

    initial begin : watchdog
        #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        fail_printed = 1'b1;
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] s;
        void'($urandom(72728));
        reset_n = 1'b0;
        drive_idle();
        ref_busy = '0;
        for (int i = 0; i < DEPTH; i++) begin
            ref_valid[i] = 1'b0;
            ref_p1[i]    = 1'b0;
            ref_p2[i]    = 1'b0;
            ref_uop[i]   = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #0.5;
        reset_n = 1'b1;

        // independent ops go straight through
        for (int i = 0; i < 4; i++) begin
            enqueue(make_uop('0, '0, 6'(10 + i), 1'b0, 1'b1));
            tick();
        end
        idle(3);

        // consumer of p20 waits for its writeback
        enqueue(make_uop('0, '0, 6'd20, 1'b0, 1'b0));
        tick();
        enqueue(make_uop(6'd20, 6'd3, 6'd23, 1'b1, 1'b1));
        tick();
        idle(4);
        wb.valid = 1'b1;
        wb.prd   = 6'd20;
        tick();
        idle(2);
        // writeback in the enqueue cycle bypasses the busy bit
        enqueue(make_uop('0, '0, 6'd21, 1'b0, 1'b0));
        tick();
        enqueue(make_uop(6'd5, 6'd21, 6'd22, 1'b1, 1'b1));
        wb.valid = 1'b1;
        wb.prd   = 6'd21;
        tick();
        idle(2);

        // lowest slot first even after slots are reused
        for (int i = 0; i < 5; i++) begin
            enqueue(make_uop('0, '0, '0, 1'b0, 1'b0));
            issue_stall = 1'b1;
            tick();
        end
        idle(2);
        for (int i = 0; i < 2; i++) begin
            enqueue(make_uop('0, '0, '0, 1'b0, 1'b0));
            issue_stall = 1'b1;
            tick();
        end
        idle(8);

        // fill under stall behind a producer of p30
        enqueue(make_uop('0, '0, 6'd30, 1'b0, 1'b0));
        issue_stall = 1'b1;
        tick();
        while (!ref_full()) begin
            enqueue(make_uop('0, '0, '0, 1'b0, 1'b0));
            issue_stall = 1'b1;
            tick();
        end
        repeat (3) begin
            issue_stall = 1'b1;
            tick();
        end
        check_equal(CHK_W'(full), CHK_W'(1'b1), "full with eight entries");

        // flush empties the full queue while p30 stays busy
        flush = 1'b1;
        tick();
        check_equal(CHK_W'(issue_valid), CHK_W'(1'b0), "issue_valid after flush");
        check_equal(CHK_W'(full), CHK_W'(1'b0), "full after flush");
        enqueue(make_uop('0, '0, '0, 1'b0, 1'b0));
        flush = 1'b1;  // the enqueue loses
        tick();
        check_equal(CHK_W'(issue_valid), CHK_W'(1'b0), "issue_valid after flush with enqueue");
        enqueue(make_uop(6'd30, '0, '0, 1'b1, 1'b0));
        tick();
        idle(4);
        wb.valid = 1'b1;
        wb.prd   = 6'd30;
        tick();
        idle(3);

        // random mix on a small register range for frequent dependencies
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            r = $urandom;
            s = $urandom;
            if ((r[1:0] != 2'b00) && !ref_full()) begin
                enqueue(make_uop({2'b00, r[7:4]}, {2'b00, r[11:8]},
                                 r[3] ? {2'b00, r[15:12]} : 6'd0, r[16], r[17]));
            end
            if (r[20:18] < 3'd3) begin
                wb.valid = 1'b1;
                wb.prd   = {2'b00, s[3:0]};
            end
            issue_stall = (r[23:21] == 3'd0);
            flush       = (s[15:8] == 8'd0);
            tick();
        end
        idle(10);

        pass_printed = 1'b1;
        $display("Simulation passed");
        $finish;
    end

    final begin
        if (!pass_printed && !fail_printed) begin
            $display("The run stopped before all tests completed");
            $display("Simulation failed");
        end
    end

endmodule

// File: iq_top.f
iq_pkg.sv
iq_entry.sv
busy_table.sv
issue_select.sv
issue_queue.sv
iq_top.sv
iq_top_sva.sv
tb_iq_top.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_iq_top
FILELIST   ?= iq_top.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Simulation passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only if the pass line shows up in the simulator output
run: build
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
